// File: bench/adc_rx_checker.sv
//******************************
// Receive path assertions
// Stream, APB and FIFO rules at the top level
//******************************
`timescale 1ns/10ps
`default_nettype none

module adc_rx_checker (
  input wire logic              clk,
  input wire logic              rst_n,
  input wire logic              psel,
  input wire logic              penable,
  input wire logic              pslverr,
  input wire logic              m_valid,
  input wire logic              m_ready,
  input wire adc_rx_pkg::word_t m_data
);

  int assert_fails = 0;

  // Stalled word must hold
  stable_data: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> $stable(m_data))
    else begin
      assert_fails++;
      $error("m_data changed while m_valid was high and m_ready low");
    end

  err_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |-> psel && penable)
    else begin
      assert_fails++;
      $error("pslverr high outside an access cycle");
    end

  idle_in_reset: assert property (@(posedge clk) !rst_n |-> !m_valid)
    else begin
      assert_fails++;
      $error("m_valid high during reset");
    end

  // A stalled word stays offered until it is taken
  valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid)
    else begin
      assert_fails++;
      $error("m_valid dropped before its word was accepted");
    end

endmodule

bind adc_rx_top adc_rx_checker checker_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .psel      (psel),
  .penable   (penable),
  .pslverr   (pslverr),
  .m_valid   (m_valid),
  .m_ready   (m_ready),
  .m_data    (m_data)
);

`default_nettype wire

// File: bench/adc_rx_tb.sv
//******************************
// ADC receive path testbench
// Vector file stimulus, APB register and overflow checks
//******************************
`timescale 1ns/10ps
`default_nettype none

`include "adc_rx_cfg.svh"

module adc_rx_tb;

  localparam int CLK_PERIOD = 4;
  localparam int TIMEOUT    = 200;

  logic                          clk;
  logic                          rst_n;
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  logic [`ADC_RX_APB_ADDR_W-1:0] paddr;
  logic [31:0]                   pwdata;
  logic [31:0]                   prdata;
  logic                          pready;
  logic                          pslverr;
  logic                          s_valid;
  adc_rx_pkg::sample_t           s_data_0;
  adc_rx_pkg::sample_t           s_data_1;
  adc_rx_pkg::sample_t           s_data_2;
  adc_rx_pkg::sample_t           s_data_3;
  logic                          m_valid;
  adc_rx_pkg::word_t             m_data;
  logic                          m_ready;

  int                  errors;
  int                  accepted;
  logic                sink_ready;
  integer              seed;
  adc_rx_pkg::word_t   exp_words [$];
  string               exp_names [$];
  adc_rx_pkg::sample_t lanes [$];

  adc_rx_top dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .s_valid  (s_valid),
    .s_data_0 (s_data_0),
    .s_data_1 (s_data_1),
    .s_data_2 (s_data_2),
    .s_data_3 (s_data_3),
    .m_valid  (m_valid),
    .m_data   (m_data),
    .m_ready  (m_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("error %s: expected %h actual %h", name, exp, act);
    end
  endtask

  //******************************
  // APB master
  //******************************
  task automatic apb_access(input logic wr, input logic [`ADC_RX_APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int tries;
    tries = 0;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    // Sample mid low phase where the access cycle is settled
    #(CLK_PERIOD/4);
    while (!pready && tries < TIMEOUT) begin
      @(negedge clk);
      #(CLK_PERIOD/4);
      tries++;
    end
    if (!pready) begin
      errors++;
      $display("APB access to address %h never saw pready", addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [`ADC_RX_APB_ADDR_W-1:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [`ADC_RX_APB_ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic err);
    apb_access(1'b0, addr, 32'd0, data, err);
  endtask

  //******************************
  // Sample source and model
  //******************************
  task automatic drive_set(input logic [15:0] d0, input logic [15:0] d1,
                           input logic [15:0] d2, input logic [15:0] d3);
    @(negedge clk);
    s_valid  = 1'b1;
    s_data_0 = d0;
    s_data_1 = d1;
    s_data_2 = d2;
    s_data_3 = d3;
    @(negedge clk);
    s_valid  = 1'b0;
  endtask

  // Enabled samples in channel order, lane 0 first, four lanes per word
  task automatic model_set(input string name, input logic [3:0] mask, input logic ob,
                           input logic [15:0] d0, input logic [15:0] d1,
                           input logic [15:0] d2, input logic [15:0] d3);
    adc_rx_pkg::sample_t d [4];
    adc_rx_pkg::word_t   w;
    d[0] = d0;
    d[1] = d1;
    d[2] = d2;
    d[3] = d3;
    for (int c = 0; c < 4; c++) begin
      if (mask[c]) begin
        lanes.push_back(ob ? {~d[c][15], d[c][14:0]} : d[c]);
      end
    end
    if (lanes.size() >= 4) begin
      for (int l = 0; l < 4; l++) begin
        w[l] = lanes.pop_front();
      end
      exp_words.push_back(w);
      exp_names.push_back(name);
    end
  endtask

  task automatic wait_drained();
    int tries;
    tries = 0;
    while (exp_words.size() != 0 && tries < TIMEOUT) begin
      @(negedge clk);
      tries++;
    end
    if (exp_words.size() != 0) begin
      errors++;
      $display("Timed out with %0d expected words never delivered", exp_words.size());
      exp_words.delete();
      exp_names.delete();
    end
  endtask

  task automatic set_sink(input logic ready);
    @(posedge clk);
    sink_ready = ready;
  endtask

  // Drain, check the word count, then restart with the new setup
  task automatic apply_config(input string name, input logic [3:0] mask, input logic ob);
    logic [31:0] val;
    logic        err;
    wait_drained();
    apb_read(`ADC_RX_REG_COUNT, val, err);
    check_value({"count_before_", name}, accepted, val);
    apb_write(`ADC_RX_REG_CTRL, {27'd0, ob, mask}, err);
    lanes.delete();
    apb_write(`ADC_RX_REG_CTRL, {23'd0, 1'b1, 3'd0, ob, mask}, err);
    accepted = 0;
  endtask

  // Handshake at the coming rising edge is known at the falling edge
  always @(negedge clk) begin
    m_ready = sink_ready;
    if (rst_n && m_valid && sink_ready) begin
      if (exp_words.size() == 0) begin
        errors++;
        $display("Output word %h arrived when no word was expected", m_data);
      end else begin
        check_value(exp_names.pop_front(), exp_words.pop_front(), m_data);
      end
      accepted++;
    end
  end

  //******************************
  // Test sequence
  //******************************
  initial begin
    int          fd;
    int          n;
    int          tries;
    string       line;
    string       name;
    string       cur_name;
    logic [31:0] mask_v;
    logic [31:0] ob_v;
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    logic [31:0] rd_val;
    logic        err;
    errors     = 0;
    accepted   = 0;
    seed       = 85;
    sink_ready = 1'b1;
    m_ready    = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    s_valid    = 1'b0;
    s_data_0   = '0;
    s_data_1   = '0;
    s_data_2   = '0;
    s_data_3   = '0;
    cur_name   = "";
    rst_n      = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset values and register access
    apb_read(`ADC_RX_REG_CTRL, rd_val, err);
    check_value("reset_ctrl", 0, rd_val);
    apb_read(`ADC_RX_REG_STATUS, rd_val, err);
    check_value("reset_status", 0, rd_val);
    apb_read(`ADC_RX_REG_COUNT, rd_val, err);
    check_value("reset_count", 0, rd_val);
    apb_write(`ADC_RX_REG_CTRL, 32'h0000_011a, err);
    apb_read(`ADC_RX_REG_CTRL, rd_val, err);
    check_value("ctrl_readback", 32'h11a, rd_val);
    apb_write(`ADC_RX_REG_COUNT, 32'h0000_0055, err);
    check_value("count_write_err", 0, err);
    apb_read(`ADC_RX_REG_COUNT, rd_val, err);
    check_value("count_write_ignored", 0, rd_val);
    apb_read(12'h00c, rd_val, err);
    check_value("bad_addr_err", 1, err);
    check_value("bad_addr_data", 0, rd_val);
    apb_write(`ADC_RX_REG_CTRL, 32'h0, err);

    // Vector file groups
    fd = $fopen("bench/adc_rx_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the sample vector file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() < 2 || line.substr(0, 0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %h %h %h %h %h %h", name, mask_v, ob_v, v0, v1, v2, v3);
        if (n != 7) begin
          errors++;
          $display("Malformed vector line: %s", line);
          continue;
        end
        if (name != cur_name) begin
          apply_config(name, mask_v[3:0], ob_v[0]);
          cur_name = name;
        end
        model_set(name, mask_v[3:0], ob_v[0], v0[15:0], v1[15:0], v2[15:0], v3[15:0]);
        drive_set(v0[15:0], v1[15:0], v2[15:0], v3[15:0]);
      end
      $fclose(fd);
    end

    // Stalled sink with twelve words into an eight word FIFO
    apply_config("overflow", 4'hf, 1'b0);
    set_sink(1'b0);
    for (int i = 0; i < 12; i++) begin
      v0 = $random(seed);
      v1 = $random(seed);
      if (i < 8) begin
        model_set("overflow", 4'hf, 1'b0, v0[15:0], v0[31:16], v1[15:0], v1[31:16]);
      end
      drive_set(v0[15:0], v0[31:16], v1[15:0], v1[31:16]);
    end
    tries  = 0;
    rd_val = '0;
    while (!rd_val[0] && tries < 20) begin
      apb_read(`ADC_RX_REG_STATUS, rd_val, err);
      tries++;
    end
    check_value("overflow_status", 1, rd_val);
    set_sink(1'b1);
    wait_drained();
    apb_write(`ADC_RX_REG_STATUS, 32'h1, err);
    apb_read(`ADC_RX_REG_STATUS, rd_val, err);
    check_value("overflow_clear", 0, rd_val);

    // Count after a final run toggle
    apply_config("final", 4'hf, 1'b0);
    apb_read(`ADC_RX_REG_COUNT, rd_val, err);
    check_value("count_after_toggle", accepted, rd_val);

    errors += dut_i.checker_i.assert_fails;
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/adc_rx_vectors.txt
# name mask offset_binary s0 s1 s2 s3 (all hex, channels I0 Q0 I1 Q1)
# All four channels, two's complement as is
all4 f 0 0001 0002 0003 0004
all4 f 0 1111 2222 3333 4444
all4 f 0 8000 7fff ffff 0000
# I0 and I1 only
two 5 0 a001 a002 a003 a004
two 5 0 b001 b002 b003 b004
two 5 0 c001 c002 c003 c004
two 5 0 d001 d002 d003 d004
# I0, Q0 and Q1, samples straddle words and the tail is dropped on stop
three b 0 0101 0202 0303 0404
three b 0 1101 1202 1303 1404
three b 0 2101 2202 2303 2404
three b 0 3101 3202 3303 3404
three b 0 4101 4202 4303 4404
# Offset binary input
obin f 1 0000 ffff 8000 7fff
obin f 1 1234 89ab c001 4002
obin3 7 1 0f0f f0f0 5555 aaaa
obin3 7 1 8001 0001 7ffe fffe
obin3 7 1 0000 8000 1000 9000
obin3 7 1 6543 e543 2222 a222

// File: list.f
+incdir+src
src/adc_rx_pkg.sv
src/adc_ctrl_regs.sv
src/adc_sample_capture.sv
src/adc_channel_pack.sv
src/adc_output_fifo.sv
src/adc_rx_top.sv
bench/adc_rx_checker.sv
bench/adc_rx_tb.sv

// File: src/adc_channel_pack.sv
//******************************
// Channel packer
// Compacts enabled samples into 64-bit words
//******************************
`timescale 1ns/10ps
`default_nettype none

`include "adc_rx_cfg.svh"

module adc_channel_pack (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 run,
  input  wire logic                 cap_valid,
  input  wire adc_rx_pkg::sample_t  cap_data_0,
  input  wire adc_rx_pkg::sample_t  cap_data_1,
  input  wire adc_rx_pkg::sample_t  cap_data_2,
  input  wire adc_rx_pkg::sample_t  cap_data_3,
  input  wire adc_rx_pkg::ch_mask_t cap_mask,
  output logic                      pk_valid,
  output adc_rx_pkg::word_t         pk_word
);

  localparam int NUM_CH = `ADC_RX_NUM_CH;
  localparam int LANES  = `ADC_RX_WORD_W / `ADC_RX_SAMPLE_W;

  adc_rx_pkg::sample_t                              chan [NUM_CH];
  logic [NUM_CH-1:0][`ADC_RX_SAMPLE_W-1:0]          comp;
  logic [2:0]                                       n_en;
  logic [2*LANES-2:0][`ADC_RX_SAMPLE_W-1:0]         merged;
  logic [2:0]                                       total;
  adc_rx_pkg::word_t                                acc;
  // Number of lanes already held in acc
  logic [1:0]                                       lvl;

  assign chan[0] = cap_data_0;
  assign chan[1] = cap_data_1;
  assign chan[2] = cap_data_2;
  assign chan[3] = cap_data_3;

  //******************************
  // Compaction and merge
  //******************************
  // Enabled samples moved down to the low lanes in channel order
  always_comb begin
    comp = '0;
    n_en = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      if (cap_mask[c]) begin
        comp[n_en[1:0]] = chan[c];
        n_en = n_en + 3'd1;
      end
    end
  end

  // New samples appended right after the held lanes
  always_comb begin
    merged = '0;
    for (int j = 0; j < NUM_CH; j++) begin
      merged[lvl + j] = comp[j];
    end
    for (int i = 0; i < LANES - 1; i++) begin
      if (i < lvl) begin
        merged[i] = acc[i];
      end
    end
  end

  // Bit 2 flags a complete word and the low bits count the leftover lanes
  assign total = {1'b0, lvl} + n_en;

  //******************************
  // Accumulator and output word
  //******************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lvl      <= '0;
      pk_valid <= 1'b0;
    end else if (!run) begin
      // Partial word dropped while stopped
      lvl      <= '0;
      pk_valid <= 1'b0;
    end else begin
      pk_valid <= cap_valid & total[2];
      if (cap_valid) begin
        lvl <= total[1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cap_valid) begin
      if (total[2]) begin
        pk_word <= merged[LANES-1:0];
        acc     <= {{`ADC_RX_SAMPLE_W{1'b0}}, merged[2*LANES-2:LANES]};
      end else begin
        acc <= merged[LANES-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/adc_ctrl_regs.sv
//******************************
// APB control and status registers
// Channel enables, format, run, overflow and word count
//******************************
`timescale 1ns/10ps
`default_nettype none

`include "adc_rx_cfg.svh"

module adc_ctrl_regs (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          psel,
  input  wire logic                          penable,
  input  wire logic                          pwrite,
  input  wire logic [`ADC_RX_APB_ADDR_W-1:0] paddr,
  input  wire logic [31:0]                   pwdata,
  input  wire logic                          overflow,
  input  wire logic                          word_sent,
  output logic      [31:0]                   prdata,
  output logic                               pready,
  output logic                               pslverr,
  output adc_rx_pkg::ch_mask_t               ch_mask,
  output logic                               offset_binary,
  output logic                               run
);

  // CTRL field positions
  localparam int FMT_BIT = 4;
  localparam int RUN_BIT = 8;

  adc_rx_pkg::reg_addr_e addr;
  logic                  access;
  logic                  addr_ok;
  logic [31:0]           rd_data;
  logic                  ctrl_wr;
  logic                  status_wr;
  logic                  count_clr;
  logic                  ovf_flag;
  logic [31:0]           word_count;

  //******************************
  // Access decode
  //******************************
  assign addr   = adc_rx_pkg::reg_addr_e'(paddr);
  assign access = psel & penable;

  always_comb begin
    addr_ok = 1'b1;
    rd_data = '0;
    case (addr)
      adc_rx_pkg::REG_CTRL:   rd_data = {23'd0, run, 3'd0, offset_binary, ch_mask};
      adc_rx_pkg::REG_STATUS: rd_data = {31'd0, ovf_flag};
      adc_rx_pkg::REG_COUNT:  rd_data = word_count;
      default:                addr_ok = 1'b0;
    endcase
  end

  // No wait states
  assign pready  = access;
  assign pslverr = access & ~addr_ok;
  assign prdata  = (access & addr_ok) ? rd_data : '0;

  assign ctrl_wr   = access & pwrite & (addr == adc_rx_pkg::REG_CTRL);
  assign status_wr = access & pwrite & (addr == adc_rx_pkg::REG_STATUS);
  // Count restarts as run goes high
  assign count_clr = ctrl_wr & pwdata[RUN_BIT] & ~run;

  //******************************
  // Register state
  //******************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ch_mask       <= '0;
      offset_binary <= 1'b0;
      run           <= 1'b0;
    end else if (ctrl_wr) begin
      ch_mask       <= pwdata[`ADC_RX_NUM_CH-1:0];
      offset_binary <= pwdata[FMT_BIT];
      run           <= pwdata[RUN_BIT];
    end
  end

  // Sticky flag where a new overflow wins over a clear in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ovf_flag <= 1'b0;
    end else if (overflow) begin
      ovf_flag <= 1'b1;
    end else if (status_wr && pwdata[0]) begin
      ovf_flag <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_count <= '0;
    end else if (count_clr) begin
      word_count <= '0;
    end else if (word_sent) begin
      word_count <= word_count + 32'd1;
    end
  end

endmodule

`default_nettype wire

// File: src/adc_output_fifo.sv
//******************************
// Output word FIFO
// Show-ahead stream output that drops and flags on overflow
//******************************
`timescale 1ns/10ps
`default_nettype none

`include "adc_rx_cfg.svh"

module adc_output_fifo #(
  // Power of two and at least 2
  parameter int DEPTH = `ADC_RX_FIFO_DEPTH
) (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               pk_valid,
  input  wire adc_rx_pkg::word_t  pk_word,
  input  wire logic               m_ready,
  output logic                    m_valid,
  output adc_rx_pkg::word_t       m_data,
  output logic                    overflow,
  output logic                    word_sent
);

  localparam int AW = $clog2(DEPTH);

  adc_rx_pkg::word_t mem [DEPTH];
  // Extra MSB tells full from empty
  logic [AW:0]       wr_ptr;
  logic [AW:0]       rd_ptr;
  logic              empty;
  logic              full;
  logic              push;
  logic              pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign push = pk_valid & ~full;
  assign pop  = m_valid & m_ready;

  // Head entry is presented directly
  assign m_valid = ~empty;
  assign m_data  = mem[rd_ptr[AW-1:0]];

  // Converter side cannot wait so a word into a full buffer is lost
  assign overflow  = pk_valid & full;
  assign word_sent = pop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= pk_word;
    end
  end

endmodule

`default_nettype wire

// File: src/adc_rx_cfg.svh
//******************************
// Receive path configuration
// Widths, FIFO depth and register offsets
//******************************
`ifndef ADC_RX_CFG_SVH
`define ADC_RX_CFG_SVH

// Converter side
`define ADC_RX_NUM_CH      4
`define ADC_RX_SAMPLE_W    16

// Packed output word and its buffer
`define ADC_RX_WORD_W      64
`define ADC_RX_FIFO_DEPTH  8

// APB register window
`define ADC_RX_APB_ADDR_W  12
`define ADC_RX_REG_CTRL    12'h000
`define ADC_RX_REG_STATUS  12'h004
`define ADC_RX_REG_COUNT   12'h008

`endif

// File: src/adc_rx_pkg.sv
//******************************
// Receive path shared types
//******************************
`default_nettype none

`include "adc_rx_cfg.svh"

package adc_rx_pkg;

  // One converter sample
  typedef logic [`ADC_RX_SAMPLE_W-1:0] sample_t;

  // Output word with lane 0 in the low bits
  typedef sample_t [`ADC_RX_WORD_W/`ADC_RX_SAMPLE_W-1:0] word_t;

  // Bit n enables channel n (I0, Q0, I1, Q1)
  typedef logic [`ADC_RX_NUM_CH-1:0] ch_mask_t;

  // Register byte offsets
  typedef enum logic [`ADC_RX_APB_ADDR_W-1:0] {
    REG_CTRL   = `ADC_RX_REG_CTRL,
    REG_STATUS = `ADC_RX_REG_STATUS,
    REG_COUNT  = `ADC_RX_REG_COUNT
  } reg_addr_e;

endpackage

`default_nettype wire

// File: src/adc_rx_top.sv
//******************************
// ADC receive path top level
// Registers plus capture, pack and FIFO stages
//******************************
`timescale 1ns/10ps
`default_nettype none

`include "adc_rx_cfg.svh"

module adc_rx_top (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  // APB slave
  input  wire logic                          psel,
  input  wire logic                          penable,
  input  wire logic                          pwrite,
  input  wire logic [`ADC_RX_APB_ADDR_W-1:0] paddr,
  input  wire logic [31:0]                   pwdata,
  output logic      [31:0]                   prdata,
  output logic                               pready,
  output logic                               pslverr,
  // Converter samples
  input  wire logic                          s_valid,
  input  wire adc_rx_pkg::sample_t           s_data_0,
  input  wire adc_rx_pkg::sample_t           s_data_1,
  input  wire adc_rx_pkg::sample_t           s_data_2,
  input  wire adc_rx_pkg::sample_t           s_data_3,
  // Word stream
  output logic                               m_valid,
  output adc_rx_pkg::word_t                  m_data,
  input  wire logic                          m_ready
);

  adc_rx_pkg::ch_mask_t ch_mask;
  logic                 offset_binary;
  logic                 run;

  logic                 cap_valid;
  adc_rx_pkg::sample_t  cap_data_0;
  adc_rx_pkg::sample_t  cap_data_1;
  adc_rx_pkg::sample_t  cap_data_2;
  adc_rx_pkg::sample_t  cap_data_3;
  adc_rx_pkg::ch_mask_t cap_mask;

  logic                 pk_valid;
  adc_rx_pkg::word_t    pk_word;

  logic                 overflow;
  logic                 word_sent;

  adc_ctrl_regs regs_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .overflow      (overflow),
    .word_sent     (word_sent),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .ch_mask       (ch_mask),
    .offset_binary (offset_binary),
    .run           (run)
  );

  //******************************
  // Sample path
  //******************************
  adc_sample_capture capture_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .run           (run),
    .ch_mask       (ch_mask),
    .offset_binary (offset_binary),
    .s_valid       (s_valid),
    .s_data_0      (s_data_0),
    .s_data_1      (s_data_1),
    .s_data_2      (s_data_2),
    .s_data_3      (s_data_3),
    .cap_valid     (cap_valid),
    .cap_data_0    (cap_data_0),
    .cap_data_1    (cap_data_1),
    .cap_data_2    (cap_data_2),
    .cap_data_3    (cap_data_3),
    .cap_mask      (cap_mask)
  );

  adc_channel_pack pack_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .cap_valid  (cap_valid),
    .cap_data_0 (cap_data_0),
    .cap_data_1 (cap_data_1),
    .cap_data_2 (cap_data_2),
    .cap_data_3 (cap_data_3),
    .cap_mask   (cap_mask),
    .pk_valid   (pk_valid),
    .pk_word    (pk_word)
  );

  adc_output_fifo #(
    .DEPTH (`ADC_RX_FIFO_DEPTH)
  ) fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .pk_valid  (pk_valid),
    .pk_word   (pk_word),
    .m_ready   (m_ready),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .overflow  (overflow),
    .word_sent (word_sent)
  );

endmodule

`default_nettype wire

// File: src/adc_sample_capture.sv
//******************************
// Sample capture stage
// Registers a strobed sample set with format and mask
//******************************
`timescale 1ns/10ps
`default_nettype none

`include "adc_rx_cfg.svh"

module adc_sample_capture (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 run,
  input  wire adc_rx_pkg::ch_mask_t ch_mask,
  input  wire logic                 offset_binary,
  input  wire logic                 s_valid,
  input  wire adc_rx_pkg::sample_t  s_data_0,
  input  wire adc_rx_pkg::sample_t  s_data_1,
  input  wire adc_rx_pkg::sample_t  s_data_2,
  input  wire adc_rx_pkg::sample_t  s_data_3,
  output logic                      cap_valid,
  output adc_rx_pkg::sample_t       cap_data_0,
  output adc_rx_pkg::sample_t       cap_data_1,
  output adc_rx_pkg::sample_t       cap_data_2,
  output adc_rx_pkg::sample_t       cap_data_3,
  output adc_rx_pkg::ch_mask_t      cap_mask
);

  logic                take;
  adc_rx_pkg::sample_t msb_flip;

  assign take = s_valid & run;

  // Offset binary to two's complement is an MSB flip
  assign msb_flip = {offset_binary, {(`ADC_RX_SAMPLE_W-1){1'b0}}};

  // A set with no enabled channel carries nothing downstream
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= take & (|ch_mask);
    end
  end

  // Mask is taken with the data so one set never mixes two masks
  always_ff @(posedge clk) begin
    if (take) begin
      cap_data_0 <= s_data_0 ^ msb_flip;
      cap_data_1 <= s_data_1 ^ msb_flip;
      cap_data_2 <= s_data_2 ^ msb_flip;
      cap_data_3 <= s_data_3 ^ msb_flip;
      cap_mask   <= ch_mask;
    end
  end

endmodule

`default_nettype wire
